// ==== hdl/execSequencer.sv ====
// Multicycle FSM. Each request is a level held until its done input, PC only moves on writeback
`timescale 1ns/1ps

module execSequencer #(
    parameter int unsigned pcStep = 1
) (
    input  logic                 clk,
    input  logic                 rst,
    input  rvCtrlPkg::instr_u    instr,
    input  logic                 instrValid,
    output logic                 instrReady,
    input  rvCtrlPkg::decoded_t  dec,
    output rvCtrlPkg::instr_u    held,
    output logic                 regReq,
    output rvCtrlPkg::regAddr_t  rs1Addr,
    output rvCtrlPkg::regAddr_t  rs2Addr,
    input  logic                 regReady,
    output logic                 operandLoad,
    output logic                 aluReq,
    input  logic                 aluDone,
    output logic                 memRead,
    input  logic                 memAck,
    output rvCtrlPkg::ctrlWord_t ctrl,
    output rvCtrlPkg::word_t     immValue,
    output logic                 rdWrite,
    output rvCtrlPkg::regAddr_t  rdAddr,
    input  rvCtrlPkg::word_t     pcIn,
    output rvCtrlPkg::word_t     pcOut
);

    typedef enum logic [2:0] {
        sIdle,
        sReadRegs,                                 // Register read request
        sExecute,                                  // ALU op or address add
        sMemWait,                                  // Memory read request
        sExtend,                                   // Load width extension
        sWriteback
    } state_t;

    state_t           state;
    state_t           stateNext;
    rvCtrlPkg::word_t pcReg;                       // Last PC handed out
    rvCtrlPkg::word_t pcNext;
    logic             supported;
    logic             isLoad;

    assign supported = (dec.opClass != rvCtrlPkg::clsNone);
    assign isLoad    = (dec.opClass == rvCtrlPkg::clsLoad);
    assign pcNext    = pcIn + rvCtrlPkg::word_t'(pcStep);

    always_comb
    begin
        stateNext = state;                         // Any wait simply holds
        case (state)
            sIdle:
            begin
                if (instrValid)
                    stateNext = sReadRegs;
            end
            sReadRegs:
            begin
                if (!supported)
                    stateNext = sIdle;             // Retire without writeback
                else if (regReady)
                    stateNext = sExecute;
            end
            sExecute:
            begin
                if (aluDone)
                    stateNext = isLoad ? sMemWait : sWriteback;
            end
            sMemWait:
            begin
                if (memAck)
                    stateNext = dec.extUseAlu ? sExtend : sWriteback; // lw skips extension
            end
            sExtend:
            begin
                if (aluDone)
                    stateNext = sWriteback;
            end
            sWriteback: stateNext = sIdle;
            default:    stateNext = sIdle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= sIdle;
            pcReg <= '0;
        end
        else
        begin
            state <= stateNext;
            if (state == sWriteback)
                pcReg <= pcNext;                   // Keep PC after retire
        end
    end

    // Instruction is only captured while idle, so fields stay stable for the whole run
    always_ff @(posedge clk)
    begin
        if (instrReady && instrValid)
            held <= instr;
    end

    assign instrReady  = (state == sIdle);
    assign regReq      = (state == sReadRegs) && supported;
    assign operandLoad = (state == sReadRegs) && supported && regReady;
    assign aluReq      = (state == sExecute) || (state == sExtend);
    assign memRead     = (state == sMemWait);
    assign rdWrite     = (state == sWriteback);

    assign rs1Addr  = dec.rs1;
    assign rs2Addr  = dec.rs2;                     // Already zero when unused
    assign rdAddr   = dec.rd;
    assign immValue = dec.imm;
    assign pcOut    = (state == sWriteback) ? pcNext : pcReg;

    always_comb
    begin
        ctrl = dec.execCtrl;
        case (state)
            sExtend:
            begin
                ctrl.aluSel = dec.extFn;           // Memory data through the ALU
                ctrl.aSel   = rvCtrlPkg::aSelBus;
            end
            sWriteback:
            begin
                if (isLoad && !dec.extUseAlu)
                    ctrl.oSel = rvCtrlPkg::oSelRegA; // Word load bypasses the ALU
                else
                    ctrl.oSel = rvCtrlPkg::oSelAlu;
            end
            default: ctrl = dec.execCtrl;
        endcase
    end

endmodule

// ==== hdl/instrDecoder.sv ====
// Pure combinational decode. Loads with reserved funct3 and unknown opcodes give class none
`timescale 1ns/1ps

module instrDecoder (
    input  rvCtrlPkg::instr_u   instr,
    output rvCtrlPkg::decoded_t dec
);

    logic [rvCtrlPkg::opcodeW-1:0] opcode;
    logic [rvCtrlPkg::funct3W-1:0] funct3;
    logic [rvCtrlPkg::imm12W-1:0]  imm12;
    logic                          regAlt;     // funct7 asks for sub or sra
    logic                          immAlt;     // Upper immediate asks for srai
    logic                          isShift;
    rvCtrlPkg::word_t              immSext;
    rvCtrlPkg::word_t              immShamt;

    // Map funct3 plus the alternate bit onto the ALU function code
    function automatic rvCtrlPkg::aluFn_t pickAluFn(
        input logic [rvCtrlPkg::funct3W-1:0] f3,
        input logic                          alt
    );
        rvCtrlPkg::aluFn_t fn;
        case (f3)
            rvCtrlPkg::f3AddSub: fn = alt ? rvCtrlPkg::aluSub : rvCtrlPkg::aluAdd;
            rvCtrlPkg::f3Sll:    fn = rvCtrlPkg::aluSll;
            rvCtrlPkg::f3Slt:    fn = rvCtrlPkg::aluSlt;
            rvCtrlPkg::f3Sltu:   fn = rvCtrlPkg::aluSltu;
            rvCtrlPkg::f3Xor:    fn = rvCtrlPkg::aluXor;
            rvCtrlPkg::f3SrlSra: fn = alt ? rvCtrlPkg::aluSra : rvCtrlPkg::aluSrl;
            rvCtrlPkg::f3Or:     fn = rvCtrlPkg::aluOr;
            default:             fn = rvCtrlPkg::aluAnd;
        endcase
        return fn;
    endfunction

    assign opcode = instr.i.opcode;                // Same bits in both layouts
    assign funct3 = instr.i.funct3;
    assign imm12  = instr.i.imm12;

    assign regAlt = (instr.r.funct7 == rvCtrlPkg::funct7Alt);
    // addi has no subtract form, so only srai looks at the upper bits
    assign immAlt = (imm12[rvCtrlPkg::imm12W-1 -: rvCtrlPkg::funct7W] == rvCtrlPkg::funct7Alt)
                    && (funct3 == rvCtrlPkg::f3SrlSra);
    assign isShift = (funct3 == rvCtrlPkg::f3Sll) || (funct3 == rvCtrlPkg::f3SrlSra);

    assign immSext  = {{(rvCtrlPkg::wordW - rvCtrlPkg::imm12W){imm12[rvCtrlPkg::imm12W-1]}},
                       imm12};                     // Sign-extended imm12
    assign immShamt = {{(rvCtrlPkg::wordW - rvCtrlPkg::shamtW){1'b0}},
                       imm12[rvCtrlPkg::shamtW-1:0]}; // Shift amount only

    always_comb
    begin
        dec           = '0;
        dec.opClass   = rvCtrlPkg::clsNone;
        dec.execCtrl  = '{aluSel: rvCtrlPkg::aluAdd, aSel: rvCtrlPkg::aSelBus,
                          bSel: rvCtrlPkg::bSelImm, oSel: rvCtrlPkg::oSelAlu};
        dec.extFn     = rvCtrlPkg::aluAdd;
        dec.extUseAlu = 1'b0;
        dec.rs1       = instr.i.rs1;
        dec.rd        = instr.i.rd;
        dec.needRs2   = 1'b0;

        case (opcode)
            rvCtrlPkg::opReg:
            begin
                dec.opClass  = rvCtrlPkg::clsRegAlu;
                dec.execCtrl = '{aluSel: pickAluFn(funct3, regAlt), aSel: rvCtrlPkg::aSelBus,
                                 bSel: rvCtrlPkg::bSelBus, oSel: rvCtrlPkg::oSelAlu};
                dec.needRs2  = 1'b1;               // Both operands from the bus
            end
            rvCtrlPkg::opImm:
            begin
                dec.opClass  = rvCtrlPkg::clsImmAlu;
                dec.execCtrl = '{aluSel: pickAluFn(funct3, immAlt), aSel: rvCtrlPkg::aSelBus,
                                 bSel: rvCtrlPkg::bSelImm, oSel: rvCtrlPkg::oSelAlu};
                dec.imm      = isShift ? immShamt : immSext;
            end
            rvCtrlPkg::opLoad:
            begin
                dec.opClass = rvCtrlPkg::clsLoad;  // Address is rs1 + imm through the ALU
                dec.imm     = immSext;
                case (funct3)
                    rvCtrlPkg::f3Lb:
                    begin
                        dec.extFn     = rvCtrlPkg::aluByteS;
                        dec.extUseAlu = 1'b1;
                    end
                    rvCtrlPkg::f3Lh:
                    begin
                        dec.extFn     = rvCtrlPkg::aluHalfS;
                        dec.extUseAlu = 1'b1;
                    end
                    rvCtrlPkg::f3Lw:  dec.extUseAlu = 1'b0; // Output straight from register A
                    rvCtrlPkg::f3Lbu:
                    begin
                        dec.extFn     = rvCtrlPkg::aluByteU;
                        dec.extUseAlu = 1'b1;
                    end
                    rvCtrlPkg::f3Lhu:
                    begin
                        dec.extFn     = rvCtrlPkg::aluHalfU;
                        dec.extUseAlu = 1'b1;
                    end
                    default: dec.opClass = rvCtrlPkg::clsNone; // Reserved width
                endcase
            end
            default: dec.opClass = rvCtrlPkg::clsNone;
        endcase

        dec.rs2 = dec.needRs2 ? instr.r.rs2 : '0; // Zero when rs2 is not read
    end

endmodule

// ==== hdl/rvController.sv ====
// Control unit top. ALU, operand registers, register file and memory stay outside
`timescale 1ns/1ps

module rvController #(
    parameter int unsigned pcStep = 1              // PC increment per retired instruction
) (
    input  logic                 clk,
    input  logic                 rst,
    input  rvCtrlPkg::instr_u    instr,
    input  logic                 instrValid,
    output logic                 instrReady,
    output logic                 regReq,
    output rvCtrlPkg::regAddr_t  rs1Addr,
    output rvCtrlPkg::regAddr_t  rs2Addr,
    input  logic                 regReady,
    output logic                 operandLoad,
    output logic                 aluReq,
    input  logic                 aluDone,
    output logic                 memRead,
    input  logic                 memAck,
    output rvCtrlPkg::ctrlWord_t ctrl,
    output rvCtrlPkg::word_t     immValue,
    output logic                 rdWrite,
    output rvCtrlPkg::regAddr_t  rdAddr,
    input  rvCtrlPkg::word_t     pcIn,
    output rvCtrlPkg::word_t     pcOut
);

    rvCtrlPkg::instr_u   held;                     // Instruction under execution
    rvCtrlPkg::decoded_t dec;

    instrDecoder uDecoder (
        .instr (held),
        .dec   (dec)
    );

    execSequencer #(
        .pcStep (pcStep)
    ) uSequencer (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .instrValid  (instrValid),
        .instrReady  (instrReady),
        .dec         (dec),
        .held        (held),
        .regReq      (regReq),
        .rs1Addr     (rs1Addr),
        .rs2Addr     (rs2Addr),
        .regReady    (regReady),
        .operandLoad (operandLoad),
        .aluReq      (aluReq),
        .aluDone     (aluDone),
        .memRead     (memRead),
        .memAck      (memAck),
        .ctrl        (ctrl),
        .immValue    (immValue),
        .rdWrite     (rdWrite),
        .rdAddr      (rdAddr),
        .pcIn        (pcIn),
        .pcOut       (pcOut)
    );

endmodule

// ==== hdl/rvCtrlPkg.sv ====
// Shared types and codes of the control unit. Only register ALU, immediate ALU and loads exist
package rvCtrlPkg;

    localparam int wordW   = 32;                    // Data, immediate and PC width
    localparam int regW    = 5;                     // Register index width
    localparam int opcodeW = 7;
    localparam int funct3W = 3;
    localparam int funct7W = 7;
    localparam int imm12W  = 12;
    localparam int shamtW  = 5;                     // Shift amount taken from imm12

    typedef logic [wordW-1:0] word_t;
    typedef logic [regW-1:0]  regAddr_t;

    localparam logic [opcodeW-1:0] opLoad = 7'd3;   // lb, lh, lw, lbu, lhu
    localparam logic [opcodeW-1:0] opImm  = 7'd19;  // ALU with immediate
    localparam logic [opcodeW-1:0] opReg  = 7'd51;  // ALU register-register

    localparam logic [funct3W-1:0] f3AddSub = 3'd0;
    localparam logic [funct3W-1:0] f3Sll    = 3'd1;
    localparam logic [funct3W-1:0] f3Slt    = 3'd2;
    localparam logic [funct3W-1:0] f3Sltu   = 3'd3;
    localparam logic [funct3W-1:0] f3Xor    = 3'd4;
    localparam logic [funct3W-1:0] f3SrlSra = 3'd5;
    localparam logic [funct3W-1:0] f3Or     = 3'd6;
    localparam logic [funct3W-1:0] f3And    = 3'd7;

    localparam logic [funct3W-1:0] f3Lb  = 3'd0;    // Load widths share funct3 space
    localparam logic [funct3W-1:0] f3Lh  = 3'd1;
    localparam logic [funct3W-1:0] f3Lw  = 3'd2;
    localparam logic [funct3W-1:0] f3Lbu = 3'd4;
    localparam logic [funct3W-1:0] f3Lhu = 3'd5;

    localparam logic [funct7W-1:0] funct7Alt = 7'b0100000; // Selects sub and sra

    typedef enum logic [4:0] {
        aluAdd   = 5'd0,
        aluSub   = 5'd1,
        aluSll   = 5'd4,
        aluSrl   = 5'd5,
        aluAnd   = 5'd8,
        aluXor   = 5'd10,
        aluOr    = 5'd11,
        aluSltu  = 5'd13,
        aluSlt   = 5'd14,
        aluSra   = 5'd15,
        aluByteS = 5'd16,                           // Sign-extend low byte
        aluHalfS = 5'd17,                           // Sign-extend low half
        aluByteU = 5'd18,                           // Zero-extend low byte
        aluHalfU = 5'd19                            // Zero-extend low half
    } aluFn_t;

    typedef enum logic [1:0] {aSelRs1 = 2'd0, aSelBus = 2'd1, aSelPc = 2'd2} aSel_t;
    typedef enum logic [1:0] {bSelRs2 = 2'd0, bSelBus = 2'd1, bSelImm = 2'd2} bSel_t;
    typedef enum logic [1:0] {oSelAlu = 2'd0, oSelRegA = 2'd1, oSelRegB = 2'd2} oSel_t;

    typedef enum logic [1:0] {clsNone, clsRegAlu, clsImmAlu, clsLoad} opClass_t;

    typedef struct packed {
        logic [funct7W-1:0] funct7;
        regAddr_t           rs2;
        regAddr_t           rs1;
        logic [funct3W-1:0] funct3;
        regAddr_t           rd;
        logic [opcodeW-1:0] opcode;
    } rType_t;

    typedef struct packed {
        logic [imm12W-1:0]  imm12;
        regAddr_t           rs1;
        logic [funct3W-1:0] funct3;
        regAddr_t           rd;
        logic [opcodeW-1:0] opcode;
    } iType_t;

    typedef union packed {
        rType_t r;                                  // Register-register view
        iType_t i;                                  // Immediate and load view
    } instr_u;

    typedef struct packed {
        aluFn_t aluSel;
        aSel_t  aSel;
        bSel_t  bSel;
        oSel_t  oSel;
    } ctrlWord_t;                                   // 11 bits

    typedef struct packed {
        opClass_t  opClass;
        ctrlWord_t execCtrl;                        // Selects for the first ALU step
        aluFn_t    extFn;                           // Load extension function
        logic      extUseAlu;                       // Clear for word loads
        word_t     imm;
        regAddr_t  rs1;
        regAddr_t  rs2;
        regAddr_t  rd;
        logic      needRs2;
    } decoded_t;

endpackage

// ==== runSim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module rvControllerTb -f rvController.f -o simv

output=$(./obj_dir/simv 2>&1 || true)
echo "$output"
echo "$output" | grep -q "TEST PASSED"

// ==== rvController.f ====
hdl/rvCtrlPkg.sv
hdl/instrDecoder.sv
hdl/execSequencer.sv
hdl/rvController.sv
tb/rvController_asserts.sv
tb/rvControllerTb.sv

// ==== tb/rvControllerTb.sv ====
// Drives one instruction at a time from a table. Responders answer after 0 to 3 random cycles
`timescale 1ns/1ps

module rvControllerTb;

    typedef struct packed {
        rvCtrlPkg::instr_u    instr;
        rvCtrlPkg::ctrlWord_t expCtrl;                // Selects seen at operandLoad
        rvCtrlPkg::word_t     expImm;
        rvCtrlPkg::regAddr_t  expRs1;
        rvCtrlPkg::regAddr_t  expRs2;                 // Zero when rs2 is not read
        rvCtrlPkg::regAddr_t  expRd;
        logic                 expWb;                  // Clear for unsupported opcodes
        logic                 isLoad;
        logic                 useExt;                 // Second ALU step expected
        rvCtrlPkg::aluFn_t    extFn;
    } entry_t;

    logic                 clk;
    logic                 rst;
    rvCtrlPkg::instr_u    instr;
    logic                 instrValid;
    logic                 instrReady;
    logic                 regReq;
    rvCtrlPkg::regAddr_t  rs1Addr;
    rvCtrlPkg::regAddr_t  rs2Addr;
    logic                 regReady;
    logic                 operandLoad;
    logic                 aluReq;
    logic                 aluDone;
    logic                 memRead;
    logic                 memAck;
    rvCtrlPkg::ctrlWord_t ctrl;
    rvCtrlPkg::word_t     immValue;
    logic                 rdWrite;
    rvCtrlPkg::regAddr_t  rdAddr;
    rvCtrlPkg::word_t     pcIn;
    rvCtrlPkg::word_t     pcOut;

    entry_t      stimTable[$];
    logic [31:0] rngState;
    int unsigned cycleCount = 0;
    int unsigned cycleLimit = 0;
    int unsigned wbCount = 0;                         // rdWrite pulses seen so far

    rvController #(.pcStep(1)) dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;                       // 20 ns period
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp)
            abortRun($sformatf("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp));
    endtask

    task automatic checkCtrl(input string name, input rvCtrlPkg::ctrlWord_t got,
                             input rvCtrlPkg::ctrlWord_t exp);
        if (got !== exp)
            abortRun($sformatf("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic checkWord(input string name, input rvCtrlPkg::word_t got,
                             input rvCtrlPkg::word_t exp);
        if (got !== exp)
            abortRun($sformatf("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic checkReg(input string name, input rvCtrlPkg::regAddr_t got,
                            input rvCtrlPkg::regAddr_t exp);
        if (got !== exp)
            abortRun($sformatf("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp));
    endtask

    function automatic logic [31:0] lcgNext();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState;
    endfunction

    function automatic int unsigned nextDelay();
        logic [31:0] r;
        r = lcgNext();
        return {30'd0, r[31:30]};                     // Upper bits, 0 to 3 cycles
    endfunction

    task automatic addReg(input logic [2:0] f3, input logic [6:0] f7, input rvCtrlPkg::aluFn_t fn,
                          input rvCtrlPkg::regAddr_t srcA, input rvCtrlPkg::regAddr_t srcB,
                          input rvCtrlPkg::regAddr_t dest);
        entry_t e;
        e = '0;
        e.instr.r = '{funct7: f7, rs2: srcB, rs1: srcA, funct3: f3, rd: dest, opcode: 7'd51};
        e.expCtrl = '{aluSel: fn, aSel: rvCtrlPkg::aSelBus, bSel: rvCtrlPkg::bSelBus,
                      oSel: rvCtrlPkg::oSelAlu};
        e.expRs1  = srcA;
        e.expRs2  = srcB;
        e.expRd   = dest;
        e.expWb   = 1'b1;
        stimTable.push_back(e);
    endtask

    function automatic entry_t makeIType(input logic [6:0] op, input logic [11:0] imm12,
                                         input logic [2:0] f3, input rvCtrlPkg::regAddr_t srcA,
                                         input rvCtrlPkg::regAddr_t dest);
        entry_t e;
        e = '0;
        e.instr.i = '{imm12: imm12, rs1: srcA, funct3: f3, rd: dest, opcode: op};
        e.expCtrl = '{aluSel: rvCtrlPkg::aluAdd, aSel: rvCtrlPkg::aSelBus,
                      bSel: rvCtrlPkg::bSelImm, oSel: rvCtrlPkg::oSelAlu};
        e.expRs1  = srcA;
        e.expRd   = dest;
        return e;
    endfunction

    task automatic addImm(input logic [11:0] imm12, input logic [2:0] f3,
                          input rvCtrlPkg::aluFn_t fn, input rvCtrlPkg::word_t imm,
                          input rvCtrlPkg::regAddr_t srcA, input rvCtrlPkg::regAddr_t dest);
        entry_t e;
        e = makeIType(7'd19, imm12, f3, srcA, dest);
        e.expCtrl.aluSel = fn;
        e.expImm = imm;
        e.expWb  = 1'b1;
        stimTable.push_back(e);
    endtask

    task automatic addLoad(input logic [2:0] f3, input logic [11:0] imm12,
                           input rvCtrlPkg::word_t imm, input logic ext,
                           input rvCtrlPkg::aluFn_t fn, input rvCtrlPkg::regAddr_t dest);
        entry_t e;
        e = makeIType(7'd3, imm12, f3, 5'd2, dest);   // Address add uses the reset ALU code
        e.expImm = imm;
        e.expWb  = 1'b1;
        e.isLoad = 1'b1;
        e.useExt = ext;
        e.extFn  = fn;
        stimTable.push_back(e);
    endtask

    task automatic buildTable();
        addReg(3'd0, 7'h00, rvCtrlPkg::aluAdd, 5'd1, 5'd2, 5'd3);
        addReg(3'd0, 7'h20, rvCtrlPkg::aluSub, 5'd4, 5'd5, 5'd6);
        addReg(3'd1, 7'h00, rvCtrlPkg::aluSll, 5'd7, 5'd8, 5'd9);
        addReg(3'd2, 7'h00, rvCtrlPkg::aluSlt, 5'd10, 5'd11, 5'd12);
        addReg(3'd3, 7'h00, rvCtrlPkg::aluSltu, 5'd13, 5'd14, 5'd15);
        addReg(3'd4, 7'h00, rvCtrlPkg::aluXor, 5'd16, 5'd17, 5'd18);
        addReg(3'd5, 7'h00, rvCtrlPkg::aluSrl, 5'd19, 5'd20, 5'd21);
        addReg(3'd5, 7'h20, rvCtrlPkg::aluSra, 5'd22, 5'd23, 5'd24);
        addReg(3'd6, 7'h00, rvCtrlPkg::aluOr, 5'd25, 5'd26, 5'd27);
        addReg(3'd7, 7'h00, rvCtrlPkg::aluAnd, 5'd28, 5'd29, 5'd31);
        addImm(12'hFFB, 3'd0, rvCtrlPkg::aluAdd, 32'hFFFF_FFFB, 5'd7, 5'd8);   // addi -5
        addImm(12'h405, 3'd0, rvCtrlPkg::aluAdd, 32'h0000_0405, 5'd1, 5'd2);   // No subi form
        addImm(12'h7FF, 3'd2, rvCtrlPkg::aluSlt, 32'h0000_07FF, 5'd3, 5'd4);
        addImm(12'h800, 3'd3, rvCtrlPkg::aluSltu, 32'hFFFF_F800, 5'd5, 5'd6);
        addImm(12'h0F0, 3'd4, rvCtrlPkg::aluXor, 32'h0000_00F0, 5'd9, 5'd10);
        addImm(12'hF00, 3'd6, rvCtrlPkg::aluOr, 32'hFFFF_FF00, 5'd11, 5'd12);
        addImm(12'h801, 3'd7, rvCtrlPkg::aluAnd, 32'hFFFF_F801, 5'd13, 5'd14);
        addImm(12'h03F, 3'd1, rvCtrlPkg::aluSll, 32'h0000_001F, 5'd15, 5'd16); // Shamt only
        addImm(12'h003, 3'd5, rvCtrlPkg::aluSrl, 32'h0000_0003, 5'd17, 5'd18);
        addImm(12'h40A, 3'd5, rvCtrlPkg::aluSra, 32'h0000_000A, 5'd19, 5'd20); // srai
        addLoad(3'd0, 12'hFFC, 32'hFFFF_FFFC, 1'b1, rvCtrlPkg::aluByteS, 5'd3);
        addLoad(3'd1, 12'h010, 32'h0000_0010, 1'b1, rvCtrlPkg::aluHalfS, 5'd5);
        addLoad(3'd2, 12'h804, 32'hFFFF_F804, 1'b0, rvCtrlPkg::aluAdd, 5'd7);  // lw
        addLoad(3'd4, 12'h001, 32'h0000_0001, 1'b1, rvCtrlPkg::aluByteU, 5'd9);
        addLoad(3'd5, 12'h7FE, 32'h0000_07FE, 1'b1, rvCtrlPkg::aluHalfU, 5'd11);
        stimTable.push_back(makeIType(7'd35, 12'h008, 3'd2, 5'd1, 5'd4)); // sw is not supported
    endtask

    task automatic finishAlu();
        int unsigned waitLen;
        checkBit("aluReq", aluReq, 1'b1);
        checkBit("memRead", memRead, 1'b0);            // No memory request before aluDone
        waitLen = nextDelay();
        repeat (waitLen)
        begin
            @(negedge clk);
            checkBit("aluReq", aluReq, 1'b1);
            checkBit("memRead", memRead, 1'b0);
        end
        aluDone = 1'b1;
        @(negedge clk);
        aluDone = 1'b0;
    endtask

    task automatic runEntry(input entry_t e);
        rvCtrlPkg::ctrlWord_t stepCtrl;
        int unsigned          wbBefore;
        int unsigned          waitLen;
        wbBefore = wbCount;
        while (!instrReady)
            @(negedge clk);
        instr      = e.instr;
        instrValid = 1'b1;
        pcIn       = lcgNext();
        @(negedge clk);
        instrValid = 1'b0;
        if (!e.expWb)
        begin
            checkBit("regReq", regReq, 1'b0);
            @(negedge clk);
            checkBit("instrReady", instrReady, 1'b1); // Back to idle without writeback
        end
        else
        begin
            checkBit("regReq", regReq, 1'b1);
            checkReg("rs1Addr", rs1Addr, e.expRs1);
            checkReg("rs2Addr", rs2Addr, e.expRs2);
            waitLen = nextDelay();
            repeat (waitLen)
            begin
                checkBit("operandLoad", operandLoad, 1'b0);
                @(negedge clk);
                checkBit("regReq", regReq, 1'b1);
            end
            regReady = 1'b1;
            #1;                                         // operandLoad follows regReady
            checkBit("operandLoad", operandLoad, 1'b1);
            checkCtrl("ctrl", ctrl, e.expCtrl);
            if (e.expCtrl.bSel == rvCtrlPkg::bSelImm)
                checkWord("immValue", immValue, e.expImm);
            @(negedge clk);
            regReady = 1'b0;
            checkCtrl("ctrl", ctrl, e.expCtrl);
            finishAlu();
            if (e.isLoad)
            begin
                waitLen = nextDelay();
                repeat (waitLen)
                begin
                    checkBit("memRead", memRead, 1'b1);
                    @(negedge clk);
                end
                checkBit("memRead", memRead, 1'b1);
                memAck = 1'b1;
                @(negedge clk);
                memAck = 1'b0;
                if (e.useExt)
                begin
                    stepCtrl        = e.expCtrl;
                    stepCtrl.aluSel = e.extFn;          // Extension of the memory data
                    stepCtrl.aSel   = rvCtrlPkg::aSelBus;
                    checkCtrl("ctrl", ctrl, stepCtrl);
                    finishAlu();
                end
            end
            stepCtrl      = e.expCtrl;
            stepCtrl.oSel = (e.isLoad && !e.useExt) ? rvCtrlPkg::oSelRegA : rvCtrlPkg::oSelAlu;
            checkBit("rdWrite", rdWrite, 1'b1);
            checkBit("aluReq", aluReq, 1'b0);           // lw has no second ALU step
            checkReg("rdAddr", rdAddr, e.expRd);
            checkCtrl("ctrl", ctrl, stepCtrl);
            checkWord("pcOut", pcOut, pcIn + 32'd1);
            @(negedge clk);
            checkBit("instrReady", instrReady, 1'b1);
        end
        if (wbCount - wbBefore != (e.expWb ? 32'd1 : 32'd0))
            abortRun($sformatf("Wrong number of rdWrite pulses for instruction %h", e.instr));
    endtask

    always @(negedge clk)
    begin
        if (rdWrite)
            wbCount <= wbCount + 1;
    end

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > cycleLimit)
            abortRun($sformatf("Timeout because the run took more than %0d cycles", cycleLimit));
    end

    initial
    begin
        rst        = 1'b1;
        instr      = '0;
        instrValid = 1'b0;
        regReady   = 1'b0;
        aluDone    = 1'b0;
        memAck     = 1'b0;
        pcIn       = '0;
        rngState   = 32'd29;                            // LCG seed
        buildTable();
        cycleLimit = stimTable.size() * 40;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        checkBit("instrReady", instrReady, 1'b1);
        checkBit("regReq", regReq, 1'b0);
        checkWord("pcOut", pcOut, 32'd0);
        foreach (stimTable[k])
            runEntry(stimTable[k]);
        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== tb/rvController_asserts.sv ====
// Handshake and reset checks on the control unit top, attached by bind. Needs assertions enabled
`timescale 1ns/1ps

module rvControllerAsserts (
    input logic                 clk,
    input logic                 rst,
    input logic                 instrReady,
    input logic                 regReq,
    input logic                 regReady,
    input rvCtrlPkg::regAddr_t  rs1Addr,
    input rvCtrlPkg::regAddr_t  rs2Addr,
    input logic                 operandLoad,
    input logic                 aluReq,
    input logic                 aluDone,
    input rvCtrlPkg::ctrlWord_t ctrl,
    input logic                 memRead,
    input logic                 memAck,
    input logic                 rdWrite,
    input rvCtrlPkg::word_t     pcOut
);

    // Register read holds with fixed addresses until regReady
    assert property (@(posedge clk) disable iff (rst)
        regReq && !regReady |=> regReq && $stable(rs1Addr) && $stable(rs2Addr))
        else $error("regReq dropped or its addresses moved before regReady");

    assert property (@(posedge clk) disable iff (rst)
        aluReq && !aluDone |=> aluReq && $stable(ctrl))     // Selects frozen during ALU step
        else $error("aluReq dropped or ctrl moved before aluDone");

    assert property (@(posedge clk) disable iff (rst) memRead && !memAck |=> memRead)
        else $error("memRead dropped before memAck");

    // Idle outputs one cycle into reset
    assert property (@(posedge clk) rst |=> instrReady && !regReq && !operandLoad && !aluReq
                     && !memRead && !rdWrite && (pcOut == '0))
        else $error("Outputs not in their idle state after reset");

endmodule

bind rvController rvControllerAsserts uAsserts (.*);
